// ==== hdl/cpuIsaPkg.sv ====
// ISA encodings; opcodes 11 and 12 are no-ops, register codes above 7 name nothing
package cpuIsaPkg;

    localparam int BYTE_W  = 8;   // data and address width
    localparam int INSTR_W = 16;  // two fetch bytes, high first

    typedef logic [BYTE_W-1:0] byte_t;

    typedef enum logic [3:0] {
        OP_BRA = 4'd0,   // pc <- imm
        OP_LD  = 4'd1,   // rx <- imm or M[AR]
        OP_ST  = 4'd2,   // M[AR] <- rx
        OP_MOV = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_NOT = 4'd6,
        OP_ADD = 4'd7,
        OP_SUB = 4'd8,
        OP_LSR = 4'd9,
        OP_LSL = 4'd10,
        OP_INC = 4'd13,  // dst <- src1 + 1
        OP_DEC = 4'd14,  // dst <- src1 - 1
        OP_BNE = 4'd15   // pc <- imm when zero clear
    } opcode_e;

    typedef enum logic [3:0] {
        REG_PC     = 4'd0,
        REG_PC_ALT = 4'd1,  // second PC alias
        REG_AR     = 4'd2,
        REG_AR_ALT = 4'd3,  // second AR alias
        REG_R1     = 4'd4,
        REG_R2     = 4'd5,
        REG_R3     = 4'd6,
        REG_R4     = 4'd7
    } regCode_e;

    typedef struct packed {
        logic       spare;     // bit 11, ignored
        logic       addrMode;  // 1 immediate, 0 direct through AR
        logic [1:0] regSel;    // R1..R4
        byte_t      imm;       // target or load value
    } addrForm_t;

    typedef struct packed {
        regCode_e dst;   // bits 11:8
        regCode_e src1;  // bits 7:4, ALU A
        regCode_e src2;  // bits 3:0, ALU B, R1..R4 only
    } regForm_t;

    typedef union packed {
        addrForm_t addrForm;  // BRA LD ST BNE
        regForm_t  regForm;   // ALU group
    } operand_u;

    typedef struct packed {
        opcode_e  opcode;  // top nibble
        operand_u ops;
    } instr_t;

endpackage

// ==== hdl/dataPathPkg.sv ====
// datapath control encodings; the sequencer never selects the srcB memory source
package dataPathPkg;

    typedef enum logic [3:0] {
        ALU_PASS_A,
        ALU_PASS_B,  // store data path
        ALU_AND,
        ALU_OR,
        ALU_NOT_A,
        ALU_ADD,
        ALU_SUB,
        ALU_SHL,     // logical, zero fill
        ALU_SHR,     // logical, zero fill
        ALU_INC_A,
        ALU_DEC_A
    } aluOp_e;

    typedef enum logic [1:0] {
        FUN_HOLD,
        FUN_INCR,
        FUN_LOAD,
        FUN_CLEAR
    } regFun_e;

    typedef enum logic [1:0] {
        SRC_A_IR_LOW,   // immediate byte
        SRC_A_MEM_OUT,  // async memory read
        SRC_A_ALU_OUT
    } srcA_e;  // register file write data

    typedef enum logic [1:0] {
        SRC_B_IR_LOW,
        SRC_B_MEM_OUT,
        SRC_B_ALU_OUT
    } srcB_e;  // PC / AR write data

    localparam logic ARF_SEL_PC = 1'b0;  // address port shows PC
    localparam logic ARF_SEL_AR = 1'b1;  // address port shows AR

    typedef struct packed {
        logic       rfWrEn;
        logic [1:0] rfWrSel;    // R1..R4
        logic [1:0] rfASel;
        logic [1:0] rfBSel;
        regFun_e    arfPcFun;
        regFun_e    arfArFun;
        logic       arfOutSel;  // also the memory address
        logic       irLoadHi;
        logic       irLoadLo;
        aluOp_e     aluOp;
        logic       aluSrcArf;  // A from ARF instead of port A
        logic       flagWr;
        logic       memWr;      // doubles as store strobe
        srcA_e      muxA;
        srcB_e      muxB;
    } ctrlWord_t;

    typedef struct packed {
        cpuIsaPkg::instr_t instr;  // current IR
        logic              zero;   // registered zero flag
    } dpStatus_t;

endpackage

// ==== hdl/regFile.sv ====
// four general registers R1..R4, no read bypass: a write shows up the cycle after
module regFile (
    input  logic             CLK,
    input  logic             rst_i,
    input  logic             wrEn_i,
    input  logic [1:0]       wrSel_i,   // 0 is R1
    input  cpuIsaPkg::byte_t wrData_i,
    input  logic [1:0]       aSel_i,
    input  logic [1:0]       bSel_i,
    output cpuIsaPkg::byte_t aData_o,
    output cpuIsaPkg::byte_t bData_o
);
    import cpuIsaPkg::*;

    byte_t regs [4];  // R1..R4 at index 0..3

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;  // all cleared
            end
        end else if (wrEn_i) begin
            regs[wrSel_i] <= wrData_i;  // one write port
        end
    end

    // two independent read ports
    assign aData_o = regs[aSel_i];
    assign bData_o = regs[bSel_i];

endmodule

// ==== hdl/addrRegFile.sv ====
// PC and AR with one shared read port; both may change in the same cycle from one write bus
module addrRegFile #(
    parameter cpuIsaPkg::byte_t resetPc = '0  // first fetch address
) (
    input  logic                 CLK,
    input  logic                 rst_i,
    input  dataPathPkg::regFun_e pcFun_i,
    input  dataPathPkg::regFun_e arFun_i,
    input  cpuIsaPkg::byte_t     wrData_i,
    input  logic                 outSel_i,  // PC or AR
    output cpuIsaPkg::byte_t     out_o
);
    import cpuIsaPkg::*;
    import dataPathPkg::*;

    byte_t pcReg;
    byte_t arReg;

    // same function set for both registers
    function automatic byte_t applyFun(regFun_e fun, byte_t cur, byte_t din);
        case (fun)
            FUN_INCR:  return cur + 1'b1;  // wraps at 255
            FUN_LOAD:  return din;
            FUN_CLEAR: return '0;
            default:   return cur;         // hold
        endcase
    endfunction

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            pcReg <= resetPc;
            arReg <= '0;
        end else begin
            pcReg <= applyFun(pcFun_i, pcReg, wrData_i);
            arReg <= applyFun(arFun_i, arReg, wrData_i);
        end
    end

    assign out_o = (outSel_i == ARF_SEL_AR) ? arReg : pcReg;  // also memory address

endmodule

// ==== hdl/instrReg.sv ====
// 16-bit IR filled a byte at a time; loading both halves in one cycle is not expected
module instrReg (
    input  logic              CLK,
    input  logic              rst_i,
    input  logic              loadHi_i,  // first fetch byte
    input  logic              loadLo_i,  // second fetch byte
    input  cpuIsaPkg::byte_t  byte_i,
    output cpuIsaPkg::instr_t instr_o
);
    import cpuIsaPkg::*;

    logic [INSTR_W-1:0] irWord;

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            irWord <= '0;
        end else begin
            if (loadHi_i) begin
                irWord[INSTR_W-1:BYTE_W] <= byte_i;  // opcode + first operand nibble
            end
            if (loadLo_i) begin
                irWord[BYTE_W-1:0] <= byte_i;  // imm or src1/src2
            end
        end
    end

    assign instr_o = instr_t'(irWord);

endmodule

// ==== hdl/alu.sv ====
// 8-bit ALU without carry, sign or overflow; only the zero flag is kept, and only on flagWr_i
module alu (
    input  logic                CLK,
    input  logic                rst_i,
    input  dataPathPkg::aluOp_e op_i,
    input  cpuIsaPkg::byte_t    a_i,
    input  cpuIsaPkg::byte_t    b_i,
    input  logic                flagWr_i,
    output cpuIsaPkg::byte_t    result_o,
    output logic                zero_o
);
    import cpuIsaPkg::*;
    import dataPathPkg::*;

    byte_t result;

    always_comb begin
        case (op_i)
            ALU_PASS_A: result = a_i;
            ALU_PASS_B: result = b_i;       // ST data
            ALU_AND:    result = a_i & b_i;
            ALU_OR:     result = a_i | b_i;
            ALU_NOT_A:  result = ~a_i;
            ALU_ADD:    result = a_i + b_i;  // carry dropped
            ALU_SUB:    result = a_i - b_i;
            ALU_SHL:    result = a_i << 1;
            ALU_SHR:    result = a_i >> 1;
            ALU_INC_A:  result = a_i + 1'b1;
            ALU_DEC_A:  result = a_i - 1'b1;
            default:    result = '0;
        endcase
    end

    assign result_o = result;

    // flag lags the result by one edge, BNE reads it next instruction
    always_ff @(posedge CLK) begin
        if (rst_i) begin
            zero_o <= 1'b0;
        end else if (flagWr_i) begin
            zero_o <= (result == '0);
        end
    end

endmodule

// ==== hdl/memory.sv ====
// unified memory, memDepth a power of two up to 256; load port works only while rst_i is high
module memory #(
    parameter int memDepth = 256
) (
    input  logic             CLK,
    input  logic             rst_i,
    input  cpuIsaPkg::byte_t addr_i,
    input  cpuIsaPkg::byte_t wrData_i,
    input  logic             wrEn_i,
    input  logic             loadEn_i,
    input  cpuIsaPkg::byte_t loadAddr_i,
    input  cpuIsaPkg::byte_t loadData_i,
    output cpuIsaPkg::byte_t rdData_o
);
    import cpuIsaPkg::*;

    localparam int addrW = $clog2(memDepth);  // upper address bits alias

    byte_t mem [memDepth];  // contents survive reset

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            if (loadEn_i) begin
                mem[loadAddr_i[addrW-1:0]] <= loadData_i;  // program image
            end
        end else if (wrEn_i) begin
            mem[addr_i[addrW-1:0]] <= wrData_i;  // ST
        end
    end

    assign rdData_o = mem[addr_i[addrW-1:0]];  // async read

endmodule

// ==== hdl/dataPath.sv ====
// register files, IR, ALU, memory and source muxes; store port mirrors memory writes
module dataPath #(
    parameter int               memDepth = 256,
    parameter cpuIsaPkg::byte_t resetPc  = '0
) (
    input  logic                   CLK,
    input  logic                   rst_i,
    input  dataPathPkg::ctrlWord_t ctrl_i,
    output dataPathPkg::dpStatus_t status_o,
    input  logic                   loadEn_i,
    input  cpuIsaPkg::byte_t       loadAddr_i,
    input  cpuIsaPkg::byte_t       loadData_i,
    output logic                   storeEn_o,
    output cpuIsaPkg::byte_t       storeAddr_o,
    output cpuIsaPkg::byte_t       storeData_o
);
    import cpuIsaPkg::*;
    import dataPathPkg::*;

    byte_t  rfAData, rfBData, rfWrData;
    byte_t  arfWrData, arfOut;   // arfOut is the memory address
    byte_t  aluA, aluResult, memRdData, irLow;
    instr_t irWord;
    logic   zeroFlag;

    assign irLow = irWord[BYTE_W-1:0];

    always_comb begin
        case (ctrl_i.muxA)  // register file write data
            SRC_A_IR_LOW:  rfWrData = irLow;
            SRC_A_MEM_OUT: rfWrData = memRdData;
            default:       rfWrData = aluResult;
        endcase
        case (ctrl_i.muxB)  // PC / AR write data
            SRC_B_IR_LOW:  arfWrData = irLow;
            default:       arfWrData = aluResult;
        endcase
    end

    assign aluA = ctrl_i.aluSrcArf ? arfOut : rfAData;

    regFile uRegFile (.CLK, .rst_i, .wrEn_i(ctrl_i.rfWrEn), .wrSel_i(ctrl_i.rfWrSel),
        .wrData_i(rfWrData), .aSel_i(ctrl_i.rfASel), .bSel_i(ctrl_i.rfBSel),
        .aData_o(rfAData), .bData_o(rfBData));

    addrRegFile #(.resetPc(resetPc)) uArf (.CLK, .rst_i, .pcFun_i(ctrl_i.arfPcFun),
        .arFun_i(ctrl_i.arfArFun), .wrData_i(arfWrData), .outSel_i(ctrl_i.arfOutSel),
        .out_o(arfOut));

    instrReg uIr (.CLK, .rst_i, .loadHi_i(ctrl_i.irLoadHi), .loadLo_i(ctrl_i.irLoadLo),
        .byte_i(memRdData), .instr_o(irWord));

    alu uAlu (.CLK, .rst_i, .op_i(ctrl_i.aluOp), .a_i(aluA), .b_i(rfBData),
        .flagWr_i(ctrl_i.flagWr), .result_o(aluResult), .zero_o(zeroFlag));

    memory #(.memDepth(memDepth)) uMem (.CLK, .rst_i, .addr_i(arfOut), .wrData_i(aluResult),
        .wrEn_i(ctrl_i.memWr), .loadEn_i, .loadAddr_i, .loadData_i, .rdData_o(memRdData));

    assign storeEn_o   = ctrl_i.memWr;  // one cycle per ST
    assign storeAddr_o = arfOut;
    assign storeData_o = aluResult;
    assign status_o    = '{instr: irWord, zero: zeroFlag};

endmodule

// ==== hdl/controlUnit.sv ====
// fixed four-cycle sequencer; unknown opcodes and register codes above 7 do nothing in EXECUTE
module controlUnit (
    input  logic                   CLK,
    input  logic                   rst_i,
    input  dataPathPkg::dpStatus_t status_i,
    output dataPathPkg::ctrlWord_t ctrl_o
);
    import cpuIsaPkg::*;
    import dataPathPkg::*;

    typedef enum logic [1:0] {
        FETCH_HI,
        FETCH_LO,
        DECODE,
        EXECUTE
    } cuState_e;

    cuState_e   state;
    opcode_e    opcodeQ;    // decoded fields, valid in EXECUTE
    logic       addrModeQ;
    logic [1:0] regSelQ;
    regCode_e   dstQ;
    regCode_e   src1Q;
    regCode_e   src2Q;
    logic       isRegForm;  // ALU group

    always_ff @(posedge CLK) begin
        if (rst_i) begin
            state <= FETCH_HI;
        end else begin
            case (state)
                FETCH_HI: state <= FETCH_LO;
                FETCH_LO: state <= DECODE;
                DECODE:   state <= EXECUTE;
                default:  state <= FETCH_HI;
            endcase
        end
    end

    // IR is complete after FETCH_LO
    always_ff @(posedge CLK) begin
        if (state == DECODE) begin
            opcodeQ   <= status_i.instr.opcode;
            addrModeQ <= status_i.instr.ops.addrForm.addrMode;
            regSelQ   <= status_i.instr.ops.addrForm.regSel;
            dstQ      <= status_i.instr.ops.regForm.dst;
            src1Q     <= status_i.instr.ops.regForm.src1;
            src2Q     <= status_i.instr.ops.regForm.src2;
        end
    end

    always_comb begin
        ctrl_o.rfWrEn    = 1'b0;
        ctrl_o.rfWrSel   = 2'd0;
        ctrl_o.rfASel    = 2'd0;
        ctrl_o.rfBSel    = 2'd0;
        ctrl_o.arfPcFun  = FUN_HOLD;
        ctrl_o.arfArFun  = FUN_HOLD;
        ctrl_o.arfOutSel = ARF_SEL_PC;  // fetch address
        ctrl_o.irLoadHi  = 1'b0;
        ctrl_o.irLoadLo  = 1'b0;
        ctrl_o.aluOp     = ALU_PASS_A;
        ctrl_o.aluSrcArf = 1'b0;
        ctrl_o.flagWr    = 1'b0;
        ctrl_o.memWr     = 1'b0;
        ctrl_o.muxA      = SRC_A_ALU_OUT;
        ctrl_o.muxB      = SRC_B_ALU_OUT;
        isRegForm        = 1'b0;
        case (state)
            FETCH_HI: begin
                ctrl_o.irLoadHi = 1'b1;
                ctrl_o.arfPcFun = FUN_INCR;
            end
            FETCH_LO: begin
                ctrl_o.irLoadLo = 1'b1;
                ctrl_o.arfPcFun = FUN_INCR;
            end
            EXECUTE: begin
                case (opcodeQ)
                    OP_BRA: begin
                        ctrl_o.arfPcFun = FUN_LOAD;
                        ctrl_o.muxB     = SRC_B_IR_LOW;
                    end
                    OP_BNE: begin
                        if (!status_i.zero) begin  // taken on nonzero
                            ctrl_o.arfPcFun = FUN_LOAD;
                            ctrl_o.muxB     = SRC_B_IR_LOW;
                        end
                    end
                    OP_LD: begin
                        ctrl_o.rfWrEn    = 1'b1;
                        ctrl_o.rfWrSel   = regSelQ;
                        ctrl_o.arfOutSel = ARF_SEL_AR;  // direct form reads M[AR]
                        ctrl_o.muxA      = addrModeQ ? SRC_A_IR_LOW : SRC_A_MEM_OUT;
                    end
                    OP_ST: begin
                        ctrl_o.memWr     = 1'b1;
                        ctrl_o.arfOutSel = ARF_SEL_AR;
                        ctrl_o.rfBSel    = regSelQ;
                        ctrl_o.aluOp     = ALU_PASS_B;
                    end
                    OP_MOV: begin ctrl_o.aluOp = ALU_PASS_A; isRegForm = 1'b1; end
                    OP_AND: begin ctrl_o.aluOp = ALU_AND;    isRegForm = 1'b1; end
                    OP_OR:  begin ctrl_o.aluOp = ALU_OR;     isRegForm = 1'b1; end
                    OP_NOT: begin ctrl_o.aluOp = ALU_NOT_A;  isRegForm = 1'b1; end
                    OP_ADD: begin ctrl_o.aluOp = ALU_ADD;    isRegForm = 1'b1; end
                    OP_SUB: begin ctrl_o.aluOp = ALU_SUB;    isRegForm = 1'b1; end
                    OP_LSR: begin ctrl_o.aluOp = ALU_SHR;    isRegForm = 1'b1; end
                    OP_LSL: begin ctrl_o.aluOp = ALU_SHL;    isRegForm = 1'b1; end
                    OP_INC: begin ctrl_o.aluOp = ALU_INC_A;  isRegForm = 1'b1; end
                    OP_DEC: begin ctrl_o.aluOp = ALU_DEC_A;  isRegForm = 1'b1; end
                    default: ;  // 11, 12 idle
                endcase
                if (isRegForm) begin
                    ctrl_o.flagWr    = 1'b1;
                    ctrl_o.aluSrcArf = (src1Q[3:2] == 2'b00);  // PC/AR codes below 4
                    ctrl_o.arfOutSel = src1Q[1] ? ARF_SEL_AR : ARF_SEL_PC;
                    ctrl_o.rfASel    = src1Q[1:0];
                    ctrl_o.rfBSel    = src2Q[1:0];  // src2 from R1..R4
                    case (dstQ)
                        REG_PC, REG_PC_ALT: ctrl_o.arfPcFun = FUN_LOAD;
                        REG_AR, REG_AR_ALT: ctrl_o.arfArFun = FUN_LOAD;
                        REG_R1, REG_R2, REG_R3, REG_R4: begin
                            ctrl_o.rfWrEn  = 1'b1;
                            ctrl_o.rfWrSel = dstQ[1:0];
                        end
                        default: ;  // no target
                    endcase
                end
            end
            default: ;  // DECODE only latches fields
        endcase
    end

endmodule

// ==== hdl/cpuTop.sv ====
// CPU top; program loads only while rst_i is high, stores appear as one-cycle strobes
module cpuTop #(
    parameter int               memDepth = 256,
    parameter cpuIsaPkg::byte_t resetPc  = '0
) (
    input  logic             CLK,
    input  logic             rst_i,
    input  logic             loadEn_i,
    input  cpuIsaPkg::byte_t loadAddr_i,
    input  cpuIsaPkg::byte_t loadData_i,
    output logic             storeEn_o,
    output cpuIsaPkg::byte_t storeAddr_o,
    output cpuIsaPkg::byte_t storeData_o
);
    import dataPathPkg::*;

    ctrlWord_t ctrl;    // sequencer to datapath
    dpStatus_t status;  // IR and zero flag back

    controlUnit uCtrl (.CLK, .rst_i, .status_i(status), .ctrl_o(ctrl));

    dataPath #(.memDepth(memDepth), .resetPc(resetPc)) uDp (.CLK, .rst_i, .ctrl_i(ctrl),
        .status_o(status), .loadEn_i, .loadAddr_i, .loadData_i, .storeEn_o, .storeAddr_o,
        .storeData_o);

endmodule

// ==== tests/storeChecker.sv ====
// checks store strobes in order, to the cycle; expected list must be filled before reset ends
module storeChecker (
    input  logic             CLK,
    input  logic             rst_i,
    input  logic             storeEn_i,
    input  cpuIsaPkg::byte_t storeAddr_i,
    input  cpuIsaPkg::byte_t storeData_i,
    output int               errCount_o,
    output int               seenCount_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import cpuIsaPkg::*;

    typedef struct packed {
        logic [31:0] cycle;  // cycles after reset release
        byte_t       addr;
        byte_t       data;
    } expStore_t;

    expStore_t expQ [$];     // oldest first
    int        cycleCnt = 0;
    int        errors   = 0;
    int        seen     = 0;

    assign errCount_o  = errors;
    assign seenCount_o = seen;

    task automatic addExpected(input logic [31:0] cycle, input byte_t addr, input byte_t data);
        expStore_t e;
        e.cycle = cycle;
        e.addr  = addr;
        e.data  = data;
        expQ.push_back(e);
    endtask

    // outputs sampled at the edge before the DUT's registers move
    always @(posedge CLK) begin
        expStore_t nxt;
        if (rst_i) begin
            cycleCnt = 0;  // first FETCH_HI is cycle 0
            if (storeEn_i !== 1'b0) begin
                $display("Error at time %0t: storeEn_o expected 0, got %b",
                    $time, storeEn_i);
                errors++;
            end
        end else begin
            if (storeEn_i === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("Store to %h with data %h at time %0t was not expected",
                        storeAddr_i, storeData_i, $time);
                    errors++;
                end else begin
                    nxt = expQ.pop_front();
                    seen++;
                    if (cycleCnt != nxt.cycle) begin
                        $display("Error at time %0t: storeEn_o cycle expected %0d, got %0d",
                            $time, nxt.cycle, cycleCnt);
                        errors++;
                    end
                    if (storeAddr_i !== nxt.addr) begin
                        $display("Error at time %0t: storeAddr_o expected %h, got %h",
                            $time, nxt.addr, storeAddr_i);
                        errors++;
                    end
                    if (storeData_i !== nxt.data) begin
                        $display("Error at time %0t: storeData_o expected %h, got %h",
                            $time, nxt.data, storeData_i);
                        errors++;
                    end
                end
            end else if (storeEn_i !== 1'b0) begin
                $display("Error at time %0t: storeEn_o expected 0 or 1, got %b",
                    $time, storeEn_i);
                errors++;
            end
            cycleCnt++;
        end
    end

endmodule

// ==== tests/cpuTb.sv ====
// one fixed program with random operands; the image is loaded while reset is high
module cpuTb;
    timeunit 1ns;
    timeprecision 100ps;
    import cpuIsaPkg::*;

    typedef struct packed {
        logic [31:0] cycle;  // cycles after reset release
        byte_t       addr;
        byte_t       data;
    } store_t;

    localparam int    memDepth     = 256;
    localparam byte_t resetPc      = 8'h00;
    localparam int    storeTimeout = 2000;  // cycles allowed per store

    logic   CLK;
    logic   rst_i;
    logic   loadEn;
    byte_t  loadAddr;
    byte_t  loadData;
    logic   storeEn;
    byte_t  storeAddr;
    byte_t  storeData;
    int     errCount;
    int     seenCount;
    int     seed = 32'h01aa_afe6;
    byte_t  image [256];   // program, data and fill
    byte_t  progPc;        // next free program byte
    store_t expStores [$];

    cpuTop #(.memDepth(memDepth), .resetPc(resetPc)) i_dut (.CLK, .rst_i, .loadEn_i(loadEn),
        .loadAddr_i(loadAddr), .loadData_i(loadData), .storeEn_o(storeEn),
        .storeAddr_o(storeAddr), .storeData_o(storeData));

    storeChecker uStoreCheck (.CLK, .rst_i, .storeEn_i(storeEn), .storeAddr_i(storeAddr),
        .storeData_i(storeData), .errCount_o(errCount), .seenCount_o(seenCount));

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    task automatic putWord(input logic [15:0] w);
        image[progPc]     = w[15:8];  // high byte first
        image[progPc + 1] = w[7:0];
        progPc += 2;
    endtask

    task automatic addrInstr(input opcode_e op, input logic imm, input int sel, input byte_t val);
        putWord({op, 1'b0, imm, sel[1:0], val});  // sel 0 is R1
    endtask

    task automatic regInstr(input opcode_e op, input regCode_e dst, input regCode_e s1,
        input regCode_e s2);
        putWord({op, dst, s1, s2});
    endtask

    task automatic aluThenStore(input opcode_e op);
        regInstr(op, REG_R3, REG_R1, REG_R2);
        addrInstr(OP_ST, 1'b0, 2, 8'h00);         // R3 out
        regInstr(OP_INC, REG_AR, REG_AR, REG_R1);  // next result slot
    endtask

    task automatic buildProgram();
        byte_t loopPc;
        int    count;
        for (int a = 0; a < 256; a++) begin
            image[a] = byte_t'(a * 37 + 11);  // odd multiplier, every address bit counts
        end
        image[8'hF0] = byte_t'($random(seed));  // direct load source
        count = 3 + ($unsigned($random(seed)) % 4);
        progPc = resetPc;
        addrInstr(OP_LD, 1'b1, 3, 8'hC0);
        regInstr(OP_MOV, REG_AR, REG_R4, REG_R1);  // results from C0 up
        for (int i = 0; i < 4; i++) begin
            addrInstr(OP_LD, 1'b1, i, byte_t'($random(seed)));
        end
        for (int i = 0; i < 4; i++) begin
            addrInstr(OP_ST, 1'b0, i, 8'h00);
            regInstr(OP_INC, REG_AR, REG_AR, REG_R1);
        end
        aluThenStore(OP_MOV);
        aluThenStore(OP_AND);
        aluThenStore(OP_OR);
        aluThenStore(OP_NOT);
        aluThenStore(OP_ADD);
        aluThenStore(OP_SUB);
        aluThenStore(OP_LSL);
        aluThenStore(OP_LSR);
        aluThenStore(OP_INC);
        aluThenStore(OP_DEC);
        addrInstr(OP_LD, 1'b1, 3, 8'hF0);
        regInstr(OP_MOV, REG_AR_ALT, REG_R4, REG_R1);  // alias code for AR
        addrInstr(OP_LD, 1'b0, 0, 8'h00);               // R1 <- M[F0]
        addrInstr(OP_LD, 1'b1, 3, 8'hE0);
        regInstr(OP_MOV, REG_AR, REG_R4, REG_R1);
        addrInstr(OP_ST, 1'b0, 0, 8'h00);
        addrInstr(OP_LD, 1'b1, 1, byte_t'(count));      // countdown in R2
        loopPc = progPc;
        regInstr(OP_DEC, REG_R2, REG_R2, REG_R2);
        addrInstr(OP_ST, 1'b0, 1, 8'h00);               // one store per pass
        addrInstr(OP_BNE, 1'b1, 0, loopPc);
        addrInstr(OP_BRA, 1'b1, 0, progPc + 8'd4);      // hops the next ST
        addrInstr(OP_ST, 1'b0, 0, 8'h00);
        addrInstr(OP_ST, 1'b0, 2, 8'h00);               // back to back
        addrInstr(OP_ST, 1'b0, 3, 8'h00);
        addrInstr(OP_BRA, 1'b1, 0, progPc);             // parks here
    endtask

    // ISA-level model, one pass per instruction, four cycles each
    function automatic void runReference();
        byte_t  mem [256];
        byte_t  regs [4];
        byte_t  pc, ar, a, b, res, hi, lo;
        logic   zero, halted, isAlu;
        int     step;
        store_t st;
        mem = image;
        regs = '{default: '0};
        pc = resetPc;
        ar = '0;
        zero = 1'b0;
        halted = 1'b0;
        step = 0;
        while (!halted && step < 1000) begin
            hi = mem[pc];
            lo = mem[pc + 8'd1];
            pc = pc + 8'd2;  // PC is past the instruction by EXECUTE
            case (lo[7:4])
                4'd0, 4'd1: a = pc;
                4'd2, 4'd3: a = ar;
                default:    a = regs[lo[5:4]];
            endcase
            b = regs[lo[1:0]];
            isAlu = 1'b1;
            case (opcode_e'(hi[7:4]))
                OP_MOV:  res = a;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_NOT:  res = ~a;
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_LSL:  res = a << 1;
                OP_LSR:  res = a >> 1;
                OP_INC:  res = a + 8'd1;
                OP_DEC:  res = a - 8'd1;
                default: isAlu = 1'b0;
            endcase
            if (isAlu) begin
                zero = (res == 8'h00);
                case (hi[3:0])
                    4'd0, 4'd1: pc = res;
                    4'd2, 4'd3: ar = res;
                    default:    regs[hi[1:0]] = res;
                endcase
            end
            case (opcode_e'(hi[7:4]))
                OP_BRA: begin
                    halted = (lo == byte_t'(pc - 8'd2));  // branch to itself
                    pc = lo;
                end
                OP_BNE: begin
                    if (!zero) begin
                        pc = lo;
                    end
                end
                OP_LD: regs[hi[1:0]] = hi[2] ? lo : mem[ar];
                OP_ST: begin
                    st.cycle = 4 * step + 3;  // EXECUTE is the fourth cycle
                    st.addr  = ar;
                    st.data  = regs[hi[1:0]];
                    mem[ar]  = st.data;
                    expStores.push_back(st);
                end
                default: ;
            endcase
            step++;
        end
    endfunction

    initial begin
        int   idle;
        int   lastSeen;
        logic timedOut;
        rst_i    = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        timedOut = 1'b0;
        buildProgram();
        runReference();
        foreach (expStores[i]) begin
            uStoreCheck.addExpected(expStores[i].cycle, expStores[i].addr, expStores[i].data);
        end
        @(posedge CLK);
        #1;
        for (int a = 0; a < 256; a++) begin  // whole image, one byte per cycle
            loadEn   = 1'b1;
            loadAddr = byte_t'(a);
            loadData = image[a];
            @(posedge CLK);
            #1;
        end
        loadEn = 1'b0;
        repeat (8) begin
            @(posedge CLK);
            #1;
        end
        rst_i = 1'b0;
        idle = 0;
        lastSeen = 0;
        while (seenCount < expStores.size() && idle < storeTimeout) begin
            @(posedge CLK);
            #1;
            if (seenCount != lastSeen) begin
                lastSeen = seenCount;  // timeout restarts per store
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (seenCount < expStores.size()) begin
            $display("Timeout: store %0d of %0d did not arrive within %0d cycles",
                seenCount + 1, expStores.size(), storeTimeout);
            timedOut = 1'b1;
        end else begin
            repeat (32) @(posedge CLK);  // CPU parked, any extra store shows here
        end
        $display("Stores expected %0d, seen %0d, errors %0d",
            expStores.size(), seenCount, errCount);
        if (errCount == 0 && !timedOut) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/cpuIsaPkg.sv
hdl/dataPathPkg.sv
hdl/regFile.sv
hdl/addrRegFile.sv
hdl/instrReg.sv
hdl/alu.sv
hdl/memory.sv
hdl/dataPath.sv
hdl/controlUnit.sv
hdl/cpuTop.sv
tests/storeChecker.sv
tests/cpuTb.sv
